//--- run.sh
#!/bin/sh
# Build and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module cache_tb -f sim.f -o cache_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/cache_sim +verilator+error+limit+10
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation ended with status $status"
  exit $status
fi

exit 0

//--- sim.f
verilog/cache_pkg.sv
verilog/mem_op_pkg.sv
verilog/line_store.sv
verilog/bus_port.sv
verilog/cache_ctrl.sv
verilog/cache_top.sv
tb/cache_assert.sv
tb/cache_tb.sv

//--- tb/cache_assert.sv
// Concurrent checks on the core port and the memory bus handshakes
// Bound into the cache top level
`timescale 1ns/1ps
`default_nettype none

module cache_assert (
  input logic                  clk,
  input logic                  reset,
  input mem_op_pkg::cpu_req_t  cpu_req,
  input mem_op_pkg::cpu_resp_t cpu_resp,
  input logic                  busy,
  input logic                  bus_reqcyc,
  input logic                  bus_reqack,
  input cache_pkg::word_t      bus_req,
  input logic                  bus_respcyc,
  input logic                  bus_respack
);

  // Failed checks so far, read by the testbench
  int fail_count = 0;

  // done is a single cycle pulse
  done_pulse: assert property (@(posedge clk) disable iff (!reset)
    cpu_resp.done |=> !cpu_resp.done)
    else begin
      fail_count++;
      $error("done stayed high for more than one cycle");
    end

  // Request and its address stay until acknowledged
  reqcyc_hold: assert property (@(posedge clk) disable iff (!reset)
    bus_reqcyc && !bus_reqack |=> bus_reqcyc && $stable(bus_req))
    else begin
      fail_count++;
      $error("bus_reqcyc or bus_req changed before bus_reqack");
    end

  respack_follows: assert property (@(posedge clk) disable iff (!reset)
    bus_respack |-> $past(bus_respcyc))
    else begin
      fail_count++;
      $error("bus_respack without bus_respcyc in the cycle before");
    end

  busy_needs_req: assert property (@(posedge clk) disable iff (!reset)
    busy |-> (cpu_req.read || cpu_req.write))
    else begin
      fail_count++;
      $error("busy high while no request is held");
    end

endmodule

`default_nettype wire

//--- tb/cache_tb.sv
// Testbench for the write-back data cache
// Random loads and stores, bus memory model with stalls
// Golden byte model, compare tasks and watchdog
`timescale 1ns/1ps
`default_nettype none

module cache_tb;
  import cache_pkg::*;
  import mem_op_pkg::*;

  localparam int    WAYS       = 2;
  localparam int    SETS       = 16;
  localparam int    CLK_PERIOD = 10;
  localparam int    NUM_REQS   = 600;
  localparam int    SEED       = 32'h157e_b956;
  // Test region is twice the cache size
  localparam int    REGION     = 4096;
  localparam int    LINES      = REGION / 64;
  localparam addr_t BASE       = 32'h0004_0000;

  logic      clk;
  logic      reset;
  cpu_req_t  cpu_req;
  cpu_resp_t cpu_resp;
  logic      busy;
  logic      bus_reqcyc;
  logic      bus_reqack;
  word_t     bus_req;
  bus_tag_e  bus_reqtag;
  logic      bus_respcyc;
  logic      bus_respack;
  word_t     bus_resp;
  bus_tag_e  bus_resptag;

  // Backing store behind the bus
  word_t      mem_words [REGION/8];
  // Byte image of the region as the core has written it
  logic [7:0] gold [REGION];

  int   stim_seed;
  int   mem_seed;
  logic traffic_started;
  // Read bursts served so far
  int   reads_issued;

  cache_top #(
    .WAYS (WAYS),
    .SETS (SETS)
  ) uut (
    .clk         (clk),
    .reset       (reset),
    .cpu_req     (cpu_req),
    .cpu_resp    (cpu_resp),
    .busy        (busy),
    .bus_reqcyc  (bus_reqcyc),
    .bus_reqack  (bus_reqack),
    .bus_req     (bus_req),
    .bus_reqtag  (bus_reqtag),
    .bus_respcyc (bus_respcyc),
    .bus_respack (bus_respack),
    .bus_resp    (bus_resp),
    .bus_resptag (bus_resptag)
  );

  bind cache_top cache_assert u_checks (
    .clk         (clk),
    .reset       (reset),
    .cpu_req     (cpu_req),
    .cpu_resp    (cpu_resp),
    .busy        (busy),
    .bus_reqcyc  (bus_reqcyc),
    .bus_reqack  (bus_reqack),
    .bus_req     (bus_req),
    .bus_respcyc (bus_respcyc),
    .bus_respack (bus_respack)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1);
  endtask

  // Start pattern of a memory word that mixes every address bit
  function automatic word_t fill_word(addr_t a);
    return {a ^ 32'h5a3c_96e1, (a * 32'h9e37_79b1) + 32'h7f4a_7c15};
  endfunction

  task automatic load_initial_contents();
    word_t w;
    for (int i = 0; i < REGION / 8; i++) begin
      w = fill_word(BASE + addr_t'(i * 8));
      mem_words[i] = w;
      for (int b = 0; b < 8; b++)
        gold[i*8 + b] = w[8*b +: 8];
    end
  endtask

  function automatic int access_bytes(mem_op_e op);
    case (op)
      LD, SD:      return 8;
      LW, LWU, SW: return 4;
      LH, LHU, SH: return 2;
      default:     return 1;
    endcase
  endfunction

  function automatic mem_op_e pick_op(logic store, int code);
    mem_op_e op;
    if (store) begin
      case (code % 4)
        0:       op = SD;
        1:       op = SW;
        2:       op = SH;
        default: op = SB;
      endcase
    end else begin
      case (code % 7)
        0:       op = LD;
        1:       op = LW;
        2:       op = LH;
        3:       op = LB;
        4:       op = LWU;
        5:       op = LHU;
        default: op = LBU;
      endcase
    end
    return op;
  endfunction

  // Little endian with the lowest address in the low byte
  task automatic apply_store(addr_t a, mem_op_e op, word_t data);
    int base;
    base = int'(a - BASE);
    for (int b = 0; b < access_bytes(op); b++)
      gold[base + b] = data[8*b +: 8];
  endtask

  function automatic word_t expected_load(addr_t a, mem_op_e op);
    word_t v;
    int    base;
    int    n;
    logic  negative;
    base = int'(a - BASE);
    n    = access_bytes(op);
    v    = '0;
    for (int b = 0; b < n; b++)
      v[8*b +: 8] = gold[base + b];
    negative = v[8*n - 1];
    // Only the narrow signed loads extend with ones
    if (negative && (op == LW || op == LH || op == LB))
      for (int b = n; b < 8; b++)
        v[8*b +: 8] = 8'hff;
    return v;
  endfunction

  function automatic line_t golden_line(addr_t a);
    line_t l;
    int    base;
    base = int'(a - BASE);
    for (int w = 0; w < BEATS; w++)
      for (int b = 0; b < 8; b++)
        l[w][8*b +: 8] = gold[base + 8*w + b];
    return l;
  endfunction

  task automatic check_load(addr_t a, mem_op_e op, word_t got);
    word_t exp;
    exp = expected_load(a, op);
    if (got !== exp)
      stop_run($sformatf("Mismatch cpu_resp.rdata: %s at %h got %h expected %h",
                         op.name(), a, got, exp));
  endtask

  task automatic check_writeback(addr_t a, line_t got);
    line_t exp;
    exp = golden_line(a);
    for (int i = 0; i < BEATS; i++)
      if (got[i] !== exp[i])
        stop_run($sformatf("Mismatch bus_req: write-back of %h word %0d got %h expected %h",
                           a, i, got[i], exp[i]));
  endtask

  task automatic check_hit(addr_t a, int latency);
    if (latency != 1)
      stop_run($sformatf("Request to resident line at %h took %0d cycles to done instead of one",
                         a, latency));
  endtask

  // A miss shows up as a read burst on the bus
  task automatic check_busy(addr_t a, logic missed, logic saw_busy);
    if (missed && !saw_busy)
      stop_run($sformatf("busy stayed low during the miss to %h", a));
    if (!missed && saw_busy)
      stop_run($sformatf("busy went high during the hit to %h", a));
  endtask

  task automatic check_bus_addr(addr_t a);
    if (a[OFFSET_W-1:0] != '0)
      stop_run($sformatf("Bus request address %h is not line aligned", a));
    if (a < BASE || a >= BASE + addr_t'(REGION))
      stop_run($sformatf("Bus request address %h lies outside the test region", a));
  endtask

  // Random stall of 0 to 3 cycles that ends on a rising edge
  task automatic wait_gap();
    int gap;
    gap = $unsigned($random(mem_seed)) % 4;
    repeat (gap) @(posedge clk);
  endtask

  // Eight data beats follow the acknowledge without gaps
  task automatic take_writeback(addr_t a);
    line_t l;
    int    idx;
    for (int i = 0; i < BEATS; i++) begin
      @(negedge clk);
      l[i] = bus_req;
    end
    check_writeback(a, l);
    idx = int'((a - BASE) >> 3);
    for (int i = 0; i < BEATS; i++)
      mem_words[idx + i] = l[i];
    // Confirmation held until the cache answers it
    @(posedge clk);
    wait_gap();
    bus_respcyc <= 1'b1;
    bus_resptag <= MEM_WRITE;
    @(negedge clk);
    while (!bus_respack)
      @(negedge clk);
    @(posedge clk);
    bus_respcyc <= 1'b0;
    bus_resptag <= MEM_NONE;
  endtask

  // Each beat is shown for one cycle, in address order
  task automatic send_line(addr_t a);
    int idx;
    int gap;
    idx = int'((a - BASE) >> 3);
    for (int i = 0; i < BEATS; i++) begin
      gap = $unsigned($random(mem_seed)) % 4;
      if (gap != 0) begin
        bus_respcyc <= 1'b0;
        bus_resptag <= MEM_NONE;
        repeat (gap) @(posedge clk);
      end
      bus_respcyc <= 1'b1;
      bus_resptag <= MEM_READ;
      bus_resp    <= mem_words[idx + i];
      @(posedge clk);
    end
    bus_respcyc <= 1'b0;
    bus_resptag <= MEM_NONE;
  endtask

  initial begin : memory_model
    addr_t    a;
    bus_tag_e tag;
    bus_reqack   = 1'b0;
    bus_respcyc  = 1'b0;
    bus_resp     = '0;
    bus_resptag  = MEM_NONE;
    reads_issued = 0;
    forever begin
      @(negedge clk);
      if (bus_reqcyc) begin
        if (!traffic_started)
          stop_run("Bus request appeared before the first core request");
        a   = addr_t'(bus_req);
        tag = bus_reqtag;
        check_bus_addr(a);
        @(posedge clk);
        wait_gap();
        bus_reqack <= 1'b1;
        @(posedge clk);
        bus_reqack <= 1'b0;
        if (tag == MEM_WRITE) begin
          take_writeback(a);
        end else if (tag == MEM_READ) begin
          reads_issued++;
          send_line(a);
        end else begin
          stop_run("Bus request carried neither a read nor a write tag");
        end
      end
    end
  end

  always @(negedge clk) begin
    if (uut.u_checks.fail_count != 0)
      stop_run("A handshake assertion failed");
  end

  initial begin : watchdog
    #(NUM_REQS * 200 * CLK_PERIOD);
    stop_run("Watchdog expired before all requests completed");
  end

  initial begin : stimulus
    logic    store;
    logic    same_line;
    logic    saw_busy;
    int      code;
    int      line;
    int      prev_line;
    int      offset;
    int      cycles;
    int      hi;
    int      lo;
    int      reads_before;
    addr_t   addr;
    mem_op_e op;
    word_t   wdata;
    stim_seed       = SEED;
    mem_seed        = ~SEED;
    traffic_started = 1'b0;
    reset           = 1'b0;
    cpu_req         = '0;
    prev_line       = -1;
    load_initial_contents();
    repeat (10) @(posedge clk);
    reset <= 1'b1;
    repeat (2) @(posedge clk);
    for (int n = 0; n < NUM_REQS; n++) begin
      // 40 % stores
      store = ($unsigned($random(stim_seed)) % 10) < 4;
      code  = $unsigned($random(stim_seed)) % 28;
      op    = pick_op(store, code);
      // Every third request or so stays in the previous line
      if (prev_line >= 0 && ($unsigned($random(stim_seed)) % 3) == 0)
        line = prev_line;
      else
        line = $unsigned($random(stim_seed)) % LINES;
      offset    = ($unsigned($random(stim_seed)) % 64) & ~(access_bytes(op) - 1);
      addr      = BASE + addr_t'(line * 64 + offset);
      same_line = (line == prev_line);
      wdata     = '0;
      if (store) begin
        hi    = $random(stim_seed);
        lo    = $random(stim_seed);
        wdata = {hi, lo};
        apply_store(addr, op, wdata);
      end
      reads_before = reads_issued;
      @(posedge clk);
      cpu_req <= '{read: !store, write: store, addr: addr, op: op, wdata: wdata};
      traffic_started = 1'b1;
      cycles   = 0;
      saw_busy = 1'b0;
      do begin
        @(negedge clk);
        cycles++;
        saw_busy = saw_busy | busy;
      end while (!cpu_resp.done);
      if (!store)
        check_load(addr, op, cpu_resp.rdata);
      check_busy(addr, reads_issued != reads_before, saw_busy);
      if (same_line)
        check_hit(addr, cycles - 1);
      prev_line = line;
      // Request drops for one cycle after done
      @(posedge clk);
      cpu_req <= '0;
    end
    @(posedge clk);
    @(negedge clk);
    if (uut.u_checks.fail_count == 0) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      stop_run("Handshake assertions failed during the run");
    end
  end

endmodule

`default_nettype wire

//--- verilog/bus_port.sv
// Bus port of the data cache
// Dirty victim write-back burst followed by a line refill burst
`timescale 1ns/1ps
`default_nettype none

module bus_port (
  input  logic                 clk,
  input  logic                 reset,
  input  cache_pkg::fill_cmd_t fill_cmd,
  output logic                 fill_done,
  output cache_pkg::line_t     fill_line,
  output logic                 bus_reqcyc,
  input  logic                 bus_reqack,
  output cache_pkg::word_t     bus_req,
  output cache_pkg::bus_tag_e  bus_reqtag,
  input  logic                 bus_respcyc,
  output logic                 bus_respack,
  input  cache_pkg::word_t     bus_resp,
  input  cache_pkg::bus_tag_e  bus_resptag
);
  import cache_pkg::*;

  localparam int BEAT_W = $clog2(BEATS);

  typedef enum logic [2:0] {
    IDLE,
    WB_REQ,
    WB_DATA,
    WB_ACK,
    RD_REQ,
    RD_DATA,
    DONE
  } state_e;

  state_e            state;
  logic [BEAT_W-1:0] beat;
  logic              read_beat;
  addr_t             rd_addr;
  addr_t             wb_addr;

  // Holds the victim line first, then collects the refill beats
  line_t             line_buf;

  // A read beat is one cycle of bus_respcyc with the read tag
  assign read_beat = (state == RD_DATA) && bus_respcyc && (bus_resptag == MEM_READ);

  always_ff @(posedge clk) begin
    if (!reset) begin
      state       <= IDLE;
      beat        <= '0;
      bus_respack <= 1'b0;
    end else begin
      bus_respack <= 1'b0;
      case (state)
        IDLE: begin
          if (fill_cmd.start) begin
            beat  <= '0;
            state <= fill_cmd.writeback ? WB_REQ : RD_REQ;
          end
        end
        WB_REQ: begin
          if (bus_reqack)
            state <= WB_DATA;
        end
        WB_DATA: begin
          // One word per cycle, no gaps
          beat <= beat + 1'b1;
          if (beat == BEAT_W'(BEATS - 1))
            state <= WB_ACK;
        end
        WB_ACK: begin
          // Memory confirms the burst once
          if (bus_respcyc) begin
            bus_respack <= 1'b1;
            state       <= RD_REQ;
          end
        end
        RD_REQ: begin
          if (bus_reqack)
            state <= RD_DATA;
        end
        RD_DATA: begin
          if (read_beat) begin
            bus_respack <= 1'b1;
            beat        <= beat + 1'b1;
            if (beat == BEAT_W'(BEATS - 1))
              state <= DONE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Burst addresses and line buffer
  always_ff @(posedge clk) begin
    if (state == IDLE && fill_cmd.start) begin
      rd_addr  <= fill_cmd.addr;
      wb_addr  <= fill_cmd.wb_addr;
      line_buf <= fill_cmd.victim_line;
    end else if (read_beat) begin
      line_buf[beat] <= bus_resp;
    end
  end

  // Request held until acknowledge, data beats follow with bus_reqcyc low
  always_comb begin
    bus_reqcyc = 1'b0;
    bus_req    = '0;
    bus_reqtag = MEM_NONE;
    case (state)
      WB_REQ: begin
        bus_reqcyc = 1'b1;
        bus_req    = word_t'(wb_addr);
        bus_reqtag = MEM_WRITE;
      end
      WB_DATA: begin
        bus_req    = line_buf[beat];
        bus_reqtag = MEM_WRITE;
      end
      RD_REQ: begin
        bus_reqcyc = 1'b1;
        bus_req    = word_t'(rd_addr);
        bus_reqtag = MEM_READ;
      end
      default: ;
    endcase
  end

  // Full line is in the buffer for the single DONE cycle
  assign fill_done = (state == DONE);
  assign fill_line = line_buf;

endmodule

`default_nettype wire

//--- verilog/cache_ctrl.sv
// Request controller of the data cache
// Hit path with load extension and store merge, miss path with fill orders
// Per-set round-robin victim choice
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl #(
  parameter int WAYS = 2,
  parameter int SETS = 16,
  localparam int WAY_W = $clog2(WAYS),
  localparam int IDX_W = $clog2(SETS),
  localparam int TAG_W = cache_pkg::ADDR_W - cache_pkg::OFFSET_W - IDX_W
) (
  input  logic                  clk,
  input  logic                  reset,
  input  mem_op_pkg::cpu_req_t  cpu_req,
  output mem_op_pkg::cpu_resp_t cpu_resp,
  output logic                  busy,
  output cache_pkg::addr_t      lookup_addr,
  output logic [WAY_W-1:0]      victim_way,
  input  logic                  hit,
  input  logic [WAY_W-1:0]      hit_way,
  input  cache_pkg::line_t      hit_line,
  input  logic                  victim_valid,
  input  logic                  victim_dirty,
  input  logic [TAG_W-1:0]      victim_tag,
  input  cache_pkg::line_t      victim_line,
  output logic                  wr_en,
  output logic [WAY_W-1:0]      wr_way,
  output cache_pkg::line_t      wr_line,
  output logic                  wr_dirty,
  output cache_pkg::fill_cmd_t  fill_cmd,
  input  logic                  fill_done,
  input  cache_pkg::line_t      fill_line
);
  import cache_pkg::*;
  import mem_op_pkg::*;

  // LOOKUP is the replay after a refill
  typedef enum logic [1:0] {IDLE, LOOKUP, FILL, DONE} state_e;

  // Shifts the addressed bytes down and extends them by opcode
  function automatic word_t load_extend(word_t w, logic [2:0] bsel, mem_op_e op);
    word_t sh;
    sh = w >> {bsel, 3'b000};
    case (op)
      LW:      return {{32{sh[31]}}, sh[31:0]};
      LH:      return {{48{sh[15]}}, sh[15:0]};
      LB:      return {{56{sh[7]}}, sh[7:0]};
      LWU:     return {32'b0, sh[31:0]};
      LHU:     return {48'b0, sh[15:0]};
      LBU:     return {56'b0, sh[7:0]};
      default: return sh;
    endcase
  endfunction

  // Byte lanes touched by a store
  function automatic word_t store_mask(mem_op_e op, logic [2:0] bsel);
    word_t m;
    case (op)
      SD:      m = '1;
      SW:      m = 64'h0000_0000_ffff_ffff;
      SH:      m = 64'h0000_0000_0000_ffff;
      default: m = 64'h0000_0000_0000_00ff;
    endcase
    return m << {bsel, 3'b000};
  endfunction

  state_e                    state;
  logic [IDX_W-1:0]          index;
  logic [OFFSET_W-4:0]       word_sel;
  logic [2:0]                byte_sel;
  word_t                     hit_word;
  word_t                     load_value;
  word_t                     wmask;
  word_t                     store_word;
  line_t                     merged_line;
  logic                      req_active;
  logic                      accept_hit;
  logic                      accept_miss;
  logic                      replay_hit;
  logic                      done_q;
  word_t                     rdata_q;
  logic [SETS-1:0][WAY_W-1:0] victim_ptr;
  logic [WAY_W-1:0]          fill_way;
  logic                      fill_start;
  logic                      fill_wb;
  addr_t                     fill_addr;
  addr_t                     fill_wb_addr;
  line_t                     fill_victim;

  // Request address drives the lookup for its whole lifetime
  assign lookup_addr = cpu_req.addr;
  assign index       = cpu_req.addr[OFFSET_W +: IDX_W];
  assign word_sel    = cpu_req.addr[OFFSET_W-1:3];
  assign byte_sel    = cpu_req.addr[2:0];
  assign victim_way  = victim_ptr[index];

  assign req_active  = cpu_req.read | cpu_req.write;
  assign accept_hit  = (state == IDLE) && req_active && hit;
  assign accept_miss = (state == IDLE) && req_active && !hit;
  assign replay_hit  = (state == LOOKUP) && hit;

  // Word select and extension for loads
  assign hit_word   = hit_line[word_sel];
  assign load_value = load_extend(hit_word, byte_sel, cpu_req.op);

  // New bytes go into the addressed lanes of the resident word
  assign wmask      = store_mask(cpu_req.op, byte_sel);
  assign store_word = (hit_word & ~wmask) | ((cpu_req.wdata << {byte_sel, 3'b000}) & wmask);

  always_comb begin
    merged_line = hit_line;
    merged_line[word_sel] = store_word;
  end

  // Refill writes a clean line into the chosen victim way
  // A store hit writes the merged line back dirty into its own way
  always_comb begin
    wr_en    = 1'b0;
    wr_way   = hit_way;
    wr_line  = merged_line;
    wr_dirty = 1'b1;
    if (state == FILL) begin
      wr_en    = fill_done;
      wr_way   = fill_way;
      wr_line  = fill_line;
      wr_dirty = 1'b0;
    end else if ((accept_hit || replay_hit) && cpu_req.write) begin
      wr_en = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!reset) begin
      state      <= IDLE;
      done_q     <= 1'b0;
      busy       <= 1'b0;
      fill_start <= 1'b0;
      victim_ptr <= '0;
    end else begin
      done_q     <= 1'b0;
      fill_start <= 1'b0;
      case (state)
        IDLE: begin
          if (accept_hit) begin
            done_q <= 1'b1;
            state  <= DONE;
          end else if (accept_miss) begin
            busy       <= 1'b1;
            fill_start <= 1'b1;
            state      <= FILL;
            // Next miss in this set evicts the following way
            if (victim_ptr[index] == WAY_W'(WAYS - 1))
              victim_ptr[index] <= '0;
            else
              victim_ptr[index] <= victim_ptr[index] + 1'b1;
          end
        end
        FILL: begin
          if (fill_done)
            state <= LOOKUP;
        end
        LOOKUP: begin
          // Fresh line is resident now, a miss here retries from IDLE
          if (hit) begin
            done_q <= 1'b1;
            busy   <= 1'b0;
            state  <= DONE;
          end else begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Load data and fill order payload
  always_ff @(posedge clk) begin
    if (accept_hit || replay_hit)
      rdata_q <= load_value;
    if (accept_miss) begin
      fill_way     <= victim_way;
      fill_wb      <= victim_valid & victim_dirty;
      fill_addr    <= line_align(cpu_req.addr);
      fill_wb_addr <= {victim_tag, index, {OFFSET_W{1'b0}}};
      fill_victim  <= victim_line;
    end
  end

  assign cpu_resp = '{done: done_q, rdata: rdata_q};

  assign fill_cmd = '{start: fill_start, writeback: fill_wb, addr: fill_addr,
                      wb_addr: fill_wb_addr, victim_line: fill_victim};

endmodule

`default_nettype wire

//--- verilog/cache_pkg.sv
// Cache geometry and address layout shared by the data cache blocks
// Word, line and bus tag types, plus the fill order sent to the bus port
`default_nettype none

package cache_pkg;

  // Byte address and data word widths
  localparam int ADDR_W = 32;
  localparam int WORD_W = 64;

  // 64 byte lines, moved as eight 64-bit bus beats
  localparam int OFFSET_W = 6;
  localparam int BEATS = 8;

  // Address is split as tag | index | offset, index width comes from SETS
  typedef logic [ADDR_W-1:0] addr_t;

  // One memory word, also one bus beat
  typedef logic [WORD_W-1:0] word_t;

  // Word 0 of the line sits at the lowest address
  typedef logic [BEATS-1:0][WORD_W-1:0] line_t;

  // Tags carried on bus_reqtag and bus_resptag
  typedef enum logic [1:0] {
    MEM_NONE  = 2'd0,
    MEM_READ  = 2'd1,
    MEM_WRITE = 2'd2
  } bus_tag_e;

  // Order from the request controller to the bus port
  // start is a one cycle strobe, the rest is held until the next start
  typedef struct packed {
    logic  start;
    logic  writeback;
    addr_t addr;
    addr_t wb_addr;
    line_t victim_line;
  } fill_cmd_t;

  // Clears the offset bits of a byte address
  function automatic addr_t line_align(addr_t a);
    return {a[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
  endfunction

endpackage

`default_nettype wire

//--- verilog/cache_top.sv
// Write-back set-associative data cache, top level
// Request controller, line store and bus port wired together
`timescale 1ns/1ps
`default_nettype none

module cache_top #(
  parameter int WAYS = 2,
  parameter int SETS = 16,
  localparam int WAY_W = $clog2(WAYS),
  localparam int TAG_W = cache_pkg::ADDR_W - cache_pkg::OFFSET_W - $clog2(SETS)
) (
  input  logic                  clk,
  input  logic                  reset,
  input  mem_op_pkg::cpu_req_t  cpu_req,
  output mem_op_pkg::cpu_resp_t cpu_resp,
  output logic                  busy,
  output logic                  bus_reqcyc,
  input  logic                  bus_reqack,
  output cache_pkg::word_t      bus_req,
  output cache_pkg::bus_tag_e   bus_reqtag,
  input  logic                  bus_respcyc,
  output logic                  bus_respack,
  input  cache_pkg::word_t      bus_resp,
  input  cache_pkg::bus_tag_e   bus_resptag
);
  import cache_pkg::*;

  // Lookup side
  addr_t            lookup_addr;
  logic [WAY_W-1:0] victim_way;
  logic             hit;
  logic [WAY_W-1:0] hit_way;
  line_t            hit_line;
  logic             victim_valid;
  logic             victim_dirty;
  logic [TAG_W-1:0] victim_tag;
  line_t            victim_line;

  // Line write side
  logic             wr_en;
  logic [WAY_W-1:0] wr_way;
  line_t            wr_line;
  logic             wr_dirty;

  // Controller to bus port
  fill_cmd_t        fill_cmd;
  logic             fill_done;
  line_t            fill_line;

  cache_ctrl #(
    .WAYS (WAYS),
    .SETS (SETS)
  ) u_ctrl (
    .clk          (clk),
    .reset        (reset),
    .cpu_req      (cpu_req),
    .cpu_resp     (cpu_resp),
    .busy         (busy),
    .lookup_addr  (lookup_addr),
    .victim_way   (victim_way),
    .hit          (hit),
    .hit_way      (hit_way),
    .hit_line     (hit_line),
    .victim_valid (victim_valid),
    .victim_dirty (victim_dirty),
    .victim_tag   (victim_tag),
    .victim_line  (victim_line),
    .wr_en        (wr_en),
    .wr_way       (wr_way),
    .wr_line      (wr_line),
    .wr_dirty     (wr_dirty),
    .fill_cmd     (fill_cmd),
    .fill_done    (fill_done),
    .fill_line    (fill_line)
  );

  line_store #(
    .WAYS (WAYS),
    .SETS (SETS)
  ) u_store (
    .clk          (clk),
    .reset        (reset),
    .lookup_addr  (lookup_addr),
    .victim_way   (victim_way),
    .hit          (hit),
    .hit_way      (hit_way),
    .hit_line     (hit_line),
    .victim_valid (victim_valid),
    .victim_dirty (victim_dirty),
    .victim_tag   (victim_tag),
    .victim_line  (victim_line),
    .wr_en        (wr_en),
    .wr_way       (wr_way),
    .wr_line      (wr_line),
    .wr_dirty     (wr_dirty)
  );

  bus_port u_bus (
    .clk         (clk),
    .reset       (reset),
    .fill_cmd    (fill_cmd),
    .fill_done   (fill_done),
    .fill_line   (fill_line),
    .bus_reqcyc  (bus_reqcyc),
    .bus_reqack  (bus_reqack),
    .bus_req     (bus_req),
    .bus_reqtag  (bus_reqtag),
    .bus_respcyc (bus_respcyc),
    .bus_respack (bus_respack),
    .bus_resp    (bus_resp),
    .bus_resptag (bus_resptag)
  );

endmodule

`default_nettype wire

//--- verilog/line_store.sv
// Line store of the data cache
// Valid, dirty, tag and data arrays per way and set
// Combinational lookup and victim read, line write at the clock edge
`timescale 1ns/1ps
`default_nettype none

module line_store #(
  parameter int WAYS = 2,
  parameter int SETS = 16,
  localparam int WAY_W = $clog2(WAYS),
  localparam int IDX_W = $clog2(SETS),
  localparam int TAG_W = cache_pkg::ADDR_W - cache_pkg::OFFSET_W - IDX_W
) (
  input  logic             clk,
  input  logic             reset,
  input  cache_pkg::addr_t lookup_addr,
  input  logic [WAY_W-1:0] victim_way,
  output logic             hit,
  output logic [WAY_W-1:0] hit_way,
  output cache_pkg::line_t hit_line,
  output logic             victim_valid,
  output logic             victim_dirty,
  output logic [TAG_W-1:0] victim_tag,
  output cache_pkg::line_t victim_line,
  input  logic             wr_en,
  input  logic [WAY_W-1:0] wr_way,
  input  cache_pkg::line_t wr_line,
  input  logic             wr_dirty
);
  import cache_pkg::*;

  // Status bits, cleared by reset
  logic [WAYS-1:0][SETS-1:0] valid;
  logic [WAYS-1:0][SETS-1:0] dirty;

  // Tag and data storage
  logic [TAG_W-1:0] tag_mem  [WAYS][SETS];
  line_t            data_mem [WAYS][SETS];

  logic [IDX_W-1:0] index;
  logic [TAG_W-1:0] tag;

  assign index = lookup_addr[OFFSET_W +: IDX_W];
  assign tag   = lookup_addr[ADDR_W-1 -: TAG_W];

  // Tag compare in every way of the indexed set
  // At most one way can match, a tag is never resident twice
  always_comb begin
    hit     = 1'b0;
    hit_way = '0;
    for (int w = 0; w < WAYS; w++) begin
      if (valid[w][index] && tag_mem[w][index] == tag) begin
        hit     = 1'b1;
        hit_way = WAY_W'(w);
      end
    end
  end

  assign hit_line = data_mem[hit_way][index];

  // State of the way the controller would evict
  assign victim_valid = valid[victim_way][index];
  assign victim_dirty = dirty[victim_way][index];
  assign victim_tag   = tag_mem[victim_way][index];
  assign victim_line  = data_mem[victim_way][index];

  always_ff @(posedge clk) begin
    if (!reset) begin
      valid <= '0;
      dirty <= '0;
    end else if (wr_en) begin
      valid[wr_way][index] <= 1'b1;
      dirty[wr_way][index] <= wr_dirty;
    end
  end

  // Tag and index of the write come from the lookup address
  always_ff @(posedge clk) begin
    if (wr_en) begin
      tag_mem[wr_way][index]  <= tag;
      data_mem[wr_way][index] <= wr_line;
    end
  end

endmodule

`default_nettype wire

//--- verilog/mem_op_pkg.sv
// Load and store opcodes of the core port
// Core request and response structs
`default_nettype none

package mem_op_pkg;

  // Loads first, then stores
  // Unsigned loads zero-extend, the others sign-extend
  typedef enum logic [3:0] {
    LD,
    LW,
    LH,
    LB,
    LWU,
    LHU,
    LBU,
    SD,
    SW,
    SH,
    SB
  } mem_op_e;

  // Core request, read and write are levels held until done
  // Address is aligned to the access size
  typedef struct packed {
    logic              read;
    logic              write;
    cache_pkg::addr_t  addr;
    mem_op_e           op;
    cache_pkg::word_t  wdata;
  } cpu_req_t;

  // done pulses for one cycle, rdata is valid with it on loads
  typedef struct packed {
    logic              done;
    cache_pkg::word_t  rdata;
  } cpu_resp_t;

endpackage

`default_nettype wire
